//--- rob_pkg.sv
// reorder buffer shared definitions
// sizes, width typedefs and packed payloads used across the rob blocks
package rob_pkg;

    // ==============================
    // sizes
    // ==============================
    localparam int ROB_DEPTH = 16;
    localparam int ROB_IDX_W = 4;
    localparam int ARCH_REGS = 32;
    localparam int PHYS_REGS = 64;
    localparam int XLEN      = 32;

    // ==============================
    // vector types
    // ==============================
    // entry index, wraps naturally at ROB_DEPTH
    typedef logic [ROB_IDX_W-1:0]         rob_idx_t;
    // occupancy or credit amount, 0 to ROB_DEPTH inclusive
    typedef logic [ROB_IDX_W:0]           rob_cnt_t;
    typedef logic [$clog2(ARCH_REGS)-1:0] arch_reg_t;
    typedef logic [$clog2(PHYS_REGS)-1:0] phys_reg_t;
    typedef logic [XLEN-1:0]              xlen_word_t;

    // ==============================
    // payloads
    // ==============================
    // dispatch request, destination mapping of one instruction
    typedef struct packed {
        logic      rd_wen;
        arch_reg_t rd_arch;
        phys_reg_t new_prf;
        phys_reg_t old_prf;
    } disp_req_t;

    // writeback from a functional unit
    typedef struct packed {
        rob_idx_t   rob_idx;
        xlen_word_t value;
    } wb_req_t;

    // one stored entry as seen at the head
    typedef struct packed {
        logic       complete;
        logic       rd_wen;
        arch_reg_t  rd_arch;
        phys_reg_t  new_prf;
        phys_reg_t  old_prf;
        xlen_word_t value;
    } rob_entry_t;

    // retired instruction handed to rename and regfile
    typedef struct packed {
        logic       rd_wen;
        arch_reg_t  rd_arch;
        phys_reg_t  new_prf;
        phys_reg_t  old_prf;
        xlen_word_t value;
    } commit_t;

endpackage

//--- rob_alloc.sv
// reorder buffer allocation
// tail pointer, occupancy count, branch rollback and credit return
`timescale 1ns/10ps

module rob_alloc import rob_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  logic     disp_valid_i,
    input  logic     mispredict_i,
    input  rob_idx_t mispredict_idx_i,
    input  logic     retire_i,
    output logic     alloc_we_o,
    output rob_idx_t alloc_idx_o,
    output logic     rob_empty_o,
    output rob_cnt_t credit_return_o
);

    rob_idx_t tail_q;
    rob_cnt_t count_q;
    rob_idx_t younger_idx;
    rob_cnt_t rollback_cnt;
    rob_cnt_t freed_cnt;
    rob_cnt_t count_next;
    rob_idx_t tail_next;

    // ==============================
    // allocation
    // ==============================
    // producer holds no credit during a mispredict, masked here as well
    assign alloc_we_o  = disp_valid_i && !mispredict_i;
    assign alloc_idx_o = tail_q;
    assign rob_empty_o = (count_q == '0);

    // ==============================
    // rollback
    // ==============================
    // entries strictly between the branch and the tail
    // full buffer with branch at head gives 15, as expected
    assign younger_idx  = tail_q - mispredict_idx_i - 1'b1;
    assign rollback_cnt = mispredict_i ? rob_cnt_t'(younger_idx) : '0;

    // commit and rollback never overlap, commit is blocked on mispredict
    assign freed_cnt = rob_cnt_t'(retire_i) + rollback_cnt;

    always_comb begin
        count_next = count_q + rob_cnt_t'(alloc_we_o) - freed_cnt;
        if (mispredict_i) begin
            // tail lands just past the branch, 4-bit wrap
            tail_next = mispredict_idx_i + 1'b1;
        end else if (alloc_we_o) begin
            tail_next = tail_q + 1'b1;
        end else begin
            tail_next = tail_q;
        end
    end

    // ==============================
    // state
    // ==============================
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            tail_q          <= '0;
            count_q         <= '0;
            credit_return_o <= '0;
        end else begin
            tail_q          <= tail_next;
            count_q         <= count_next;
            // freed entries go back to the producer next cycle
            credit_return_o <= freed_cnt;
        end
    end

endmodule

//--- rob_entry_table.sv
// reorder buffer entry storage
// written at dispatch and writeback, head entry read combinationally
`timescale 1ns/10ps

module rob_entry_table import rob_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       alloc_we_i,
    input  rob_idx_t   alloc_idx_i,
    input  disp_req_t  disp_req_i,
    input  logic       wb_valid_i,
    input  wb_req_t    wb_req_i,
    input  rob_idx_t   head_idx_i,
    output rob_entry_t head_entry_o
);

    // completion flags per entry
    logic [ROB_DEPTH-1:0] complete_q;
    // destination mapping written at dispatch
    disp_req_t            req_q   [ROB_DEPTH];
    // result written at writeback
    xlen_word_t           value_q [ROB_DEPTH];

    // ==============================
    // completion flags
    // ==============================
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            complete_q <= '0;
        end else begin
            // fresh or reused entry starts incomplete
            if (alloc_we_i) begin
                complete_q[alloc_idx_i] <= 1'b0;
            end
            // writeback still lands during a rollback cycle
            if (wb_valid_i) begin
                complete_q[wb_req_i.rob_idx] <= 1'b1;
            end
        end
    end

    // ==============================
    // payload storage
    // ==============================
    always_ff @(posedge clock) begin
        if (alloc_we_i) begin
            req_q[alloc_idx_i] <= disp_req_i;
        end
        if (wb_valid_i) begin
            value_q[wb_req_i.rob_idx] <= wb_req_i.value;
        end
    end

    // head read port
    always_comb begin
        head_entry_o.complete = complete_q[head_idx_i];
        head_entry_o.rd_wen   = req_q[head_idx_i].rd_wen;
        head_entry_o.rd_arch  = req_q[head_idx_i].rd_arch;
        head_entry_o.new_prf  = req_q[head_idx_i].new_prf;
        head_entry_o.old_prf  = req_q[head_idx_i].old_prf;
        head_entry_o.value    = value_q[head_idx_i];
    end

endmodule

//--- rob_commit.sv
// reorder buffer commit
// head pointer, in-order retire decision and registered commit payload
`timescale 1ns/10ps

module rob_commit import rob_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  rob_entry_t head_entry_i,
    input  logic       rob_empty_i,
    input  logic       mispredict_i,
    output rob_idx_t   head_idx_o,
    output logic       retire_o,
    output logic       commit_valid_o,
    output commit_t    commit_o
);

    rob_idx_t head_q;

    assign head_idx_o = head_q;

    // ==============================
    // retire decision
    // ==============================
    // oldest entry done, nothing pending, no rollback this cycle
    assign retire_o = !rob_empty_i && head_entry_i.complete && !mispredict_i;

    // head pointer and commit strobe
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            head_q         <= '0;
            commit_valid_o <= 1'b0;
        end else begin
            commit_valid_o <= retire_o;
            if (retire_o) begin
                // wraps from 15 to 0
                head_q <= head_q + 1'b1;
            end
        end
    end

    // ==============================
    // commit payload
    // ==============================
    // held until the next retire, only valid with the strobe
    always_ff @(posedge clock) begin
        if (retire_o) begin
            commit_o.rd_wen  <= head_entry_i.rd_wen;
            commit_o.rd_arch <= head_entry_i.rd_arch;
            commit_o.new_prf <= head_entry_i.new_prf;
            commit_o.old_prf <= head_entry_i.old_prf;
            commit_o.value   <= head_entry_i.value;
        end
    end

endmodule

//--- rob_top.sv
// reorder buffer top level
// 16 entries, one dispatch, one writeback and one commit per cycle
`timescale 1ns/10ps

module rob_top import rob_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    // dispatch
    input  logic      disp_valid_i,
    input  disp_req_t disp_req_i,
    output rob_idx_t  disp_rob_idx_o,
    // writeback
    input  logic      wb_valid_i,
    input  wb_req_t   wb_req_i,
    // branch rollback
    input  logic      mispredict_i,
    input  rob_idx_t  mispredict_idx_i,
    // commit
    output logic      commit_valid_o,
    output commit_t   commit_o,
    // flow control back to the producer
    output rob_cnt_t  credit_return_o
);

    logic       alloc_we;
    rob_idx_t   alloc_idx;
    logic       rob_empty;
    logic       retire;
    rob_idx_t   head_idx;
    rob_entry_t head_entry;

    // allocated index is the tail, visible before the edge
    assign disp_rob_idx_o = alloc_idx;

    // ==============================
    // tail, count and credits
    // ==============================
    rob_alloc u_rob_alloc (
        .clock            (clock),
        .reset            (reset),
        .disp_valid_i     (disp_valid_i),
        .mispredict_i     (mispredict_i),
        .mispredict_idx_i (mispredict_idx_i),
        .retire_i         (retire),
        .alloc_we_o       (alloc_we),
        .alloc_idx_o      (alloc_idx),
        .rob_empty_o      (rob_empty),
        .credit_return_o  (credit_return_o)
    );

    // entry storage
    rob_entry_table u_rob_entry_table (
        .clock        (clock),
        .reset        (reset),
        .alloc_we_i   (alloc_we),
        .alloc_idx_i  (alloc_idx),
        .disp_req_i   (disp_req_i),
        .wb_valid_i   (wb_valid_i),
        .wb_req_i     (wb_req_i),
        .head_idx_i   (head_idx),
        .head_entry_o (head_entry)
    );

    // head and in-order retire
    rob_commit u_rob_commit (
        .clock          (clock),
        .reset          (reset),
        .head_entry_i   (head_entry),
        .rob_empty_i    (rob_empty),
        .mispredict_i   (mispredict_i),
        .head_idx_o     (head_idx),
        .retire_o       (retire),
        .commit_valid_o (commit_valid_o),
        .commit_o       (commit_o)
    );

endmodule

//--- tb_clock_gen.sv
// testbench clock source
// free running, 4 ns period, starts low
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clock_o
);

    // half of the 4 ns period
    localparam real HALF_PERIOD = 2.0;

    initial begin
        clock_o = 1'b0;
        forever #(HALF_PERIOD) clock_o = ~clock_o;
    end

endmodule

//--- tb_rob.sv
// reorder buffer testbench
// table driven dispatch, writeback and rollback against a dispatch order queue model
`timescale 1ns/10ps

module tb_rob import rob_pkg::*; ();

    localparam int MAX_AGES      = 128;
    localparam int TIMEOUT_SLACK = 40;
    localparam int RESET_CYCLES  = 5;

    // one table row, one cycle of stimulus, ages count dispatches from 0
    typedef struct packed {
        logic disp;
        int   wb_age;
        logic mp;
        int   mp_age;
    } row_t;

    logic       clock;
    logic       reset;
    logic       disp_valid;
    disp_req_t  disp_req;
    rob_idx_t   disp_rob_idx;
    logic       wb_valid;
    wb_req_t    wb_req;
    logic       mispredict;
    rob_idx_t   mispredict_idx;
    logic       commit_valid;
    commit_t    commit_data;
    rob_cnt_t   credit_return;

    // ==============================
    // reference model state
    // ==============================
    row_t       rows[$];
    // live ages, oldest first
    int         live_q[$];
    disp_req_t  exp_req [MAX_AGES];
    xlen_word_t exp_val [MAX_AGES];
    logic       written [MAX_AGES];
    int         age_idx [MAX_AGES];
    int         next_age;
    int         exp_tail;
    int         credits;
    int         credit_sum;
    int         commit_cnt;
    int         kill_cnt;
    int         value_errs;
    int         flow_errs;
    int         cycle_cnt;
    int         cycle_limit;
    integer     seed;

    tb_clock_gen u_tb_clock_gen (
        .clock_o (clock)
    );

    rob_top u_rob_top (
        .clock            (clock),
        .reset            (reset),
        .disp_valid_i     (disp_valid),
        .disp_req_i       (disp_req),
        .disp_rob_idx_o   (disp_rob_idx),
        .wb_valid_i       (wb_valid),
        .wb_req_i         (wb_req),
        .mispredict_i     (mispredict),
        .mispredict_idx_i (mispredict_idx),
        .commit_valid_o   (commit_valid),
        .commit_o         (commit_data),
        .credit_return_o  (credit_return)
    );

    // cycle limit, guards against a stuck run
    always @(posedge clock) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("run stopped after %0d cycles, cycle limit reached", cycle_cnt);
            $display("sim failed");
            $finish;
        end
    end

    function automatic int find_live(input int age);
        int pos;
        pos = -1;
        foreach (live_q[i]) begin
            if (live_q[i] == age) begin
                pos = i;
            end
        end
        return pos;
    endfunction

    // oldest live age still waiting for its result
    function automatic int oldest_unwritten();
        int age;
        age = -1;
        foreach (live_q[i]) begin
            if (age < 0 && !written[live_q[i]]) begin
                age = live_q[i];
            end
        end
        return age;
    endfunction

    task automatic add_row(input logic d, input int wb, input logic m, input int ma);
        row_t r;
        r.disp   = d;
        r.wb_age = wb;
        r.mp     = m;
        r.mp_age = ma;
        rows.push_back(r);
    endtask

    // ==============================
    // stimulus table
    // ==============================
    task automatic build_table();
        int wb_order[16];
        int k;
        wb_order = '{3, 0, 7, 1, 2, 12, 5, 4, 6, 15, 8, 10, 9, 11, 13, 14};
        // fill all 16, then one more dispatch that must stall on credits
        for (k = 0; k < 17; k++) begin
            add_row(1'b1, -1, 1'b0, -1);
        end
        // scrambled writebacks, refills wrap the tail past 15
        for (k = 0; k < 16; k++) begin
            add_row(1'b1, wb_order[k], 1'b0, -1);
        end
        add_row(1'b1, 18, 1'b0, -1);
        add_row(1'b1, 16, 1'b0, -1);
        add_row(1'b1, 20, 1'b0, -1);
        add_row(1'b1, 17, 1'b0, -1);
        // rollback to age 20 with an older writeback in the same cycle
        add_row(1'b0, 19, 1'b1, 20);
        add_row(1'b1, -1, 1'b0, -1);
        add_row(1'b1, 31, 1'b0, -1);
        add_row(1'b1, 32, 1'b0, -1);
        // single younger entry
        add_row(1'b0, -1, 1'b1, 32);
        add_row(1'b1, -1, 1'b0, -1);
        // branch is the youngest, nothing to drop
        add_row(1'b0, 34, 1'b1, 34);
        // fill again with no writeback, then roll back to the head
        for (k = 0; k < 17; k++) begin
            add_row(1'b1, -1, 1'b0, -1);
        end
        add_row(1'b0, -1, 1'b1, 35);
        add_row(1'b1, -1, 1'b0, -1);
        add_row(1'b0, 35, 1'b0, -1);
        add_row(1'b1, 51, 1'b0, -1);
    endtask

    task automatic check_reset_state();
        if (commit_valid !== 1'b0) begin
            $display("Fail commit_valid_o: got %h expected 0", commit_valid);
            value_errs++;
        end
        if (credit_return !== '0) begin
            $display("Fail credit_return_o: got %h expected 00", credit_return);
            value_errs++;
        end
        if (disp_rob_idx !== '0) begin
            $display("Fail disp_rob_idx_o: got %h expected 0", disp_rob_idx);
            value_errs++;
        end
    endtask

    // ==============================
    // one cycle, model first, then drive, then check
    // ==============================
    task automatic run_cycle(input row_t row);
        int          mp_pos;
        int          wb_pos;
        int          n_kill;
        int          head_age;
        int          new_age;
        int          k;
        logic        do_disp;
        logic        do_wb;
        logic        do_mp;
        logic        exp_retire;
        logic [31:0] rnd;
        commit_t     exp_commit;
        rob_cnt_t    exp_credit;

        // branch must still be live
        mp_pos     = row.mp ? find_live(row.mp_age) : -1;
        do_mp      = (mp_pos >= 0);
        // head retires only if its result landed at an earlier edge
        exp_retire = !do_mp && (live_q.size() > 0) && written[live_q[0]];
        exp_commit = '0;
        head_age   = -1;
        if (exp_retire) begin
            head_age           = live_q[0];
            exp_commit.rd_wen  = exp_req[head_age].rd_wen;
            exp_commit.rd_arch = exp_req[head_age].rd_arch;
            exp_commit.new_prf = exp_req[head_age].new_prf;
            exp_commit.old_prf = exp_req[head_age].old_prf;
            exp_commit.value   = exp_val[head_age];
            live_q.delete(0);
            commit_cnt++;
        end
        // drop everything younger than the branch
        n_kill = 0;
        if (do_mp) begin
            n_kill = live_q.size() - 1 - mp_pos;
            for (k = 0; k < n_kill; k++) begin
                live_q.delete(live_q.size() - 1);
            end
            exp_tail = (age_idx[row.mp_age] + 1) % ROB_DEPTH;
            kill_cnt += n_kill;
        end
        wb_pos  = (row.wb_age >= 0) ? find_live(row.wb_age) : -1;
        do_wb   = (wb_pos >= 0);
        // producer holds back without credits or during a mispredict
        do_disp = row.disp && !do_mp && (credits > 0) && (next_age < MAX_AGES);

        disp_valid     = do_disp;
        wb_valid       = do_wb;
        mispredict     = do_mp;
        mispredict_idx = do_mp ? rob_idx_t'(age_idx[row.mp_age]) : '0;
        if (do_wb) begin
            rnd                 = $random(seed);
            exp_val[row.wb_age] = rnd;
            written[row.wb_age] = 1'b1;
            wb_req.rob_idx      = rob_idx_t'(age_idx[row.wb_age]);
            wb_req.value        = rnd;
        end
        if (do_disp) begin
            new_age = next_age;
            next_age++;
            rnd              = $random(seed);
            exp_req[new_age] = rnd[17:0];
            disp_req         = rnd[17:0];
            // allocated index is visible before the edge
            if (int'(disp_rob_idx) != exp_tail) begin
                $display("Fail disp_rob_idx_o: got %h expected %h",
                         disp_rob_idx, exp_tail[3:0]);
                value_errs++;
            end
            age_idx[new_age] = exp_tail;
            exp_tail         = (exp_tail + 1) % ROB_DEPTH;
            written[new_age] = 1'b0;
            live_q.push_back(new_age);
            credits--;
        end
        exp_credit = rob_cnt_t'(n_kill + (exp_retire ? 1 : 0));

        @(posedge clock);
        #1;
        if (commit_valid !== exp_retire) begin
            $display("Fail commit_valid_o: got %h expected %h", commit_valid, exp_retire);
            value_errs++;
        end else if (exp_retire && commit_data !== exp_commit) begin
            $display("Fail commit_o: got %h expected %h for age %0d",
                     commit_data, exp_commit, head_age);
            value_errs++;
        end
        if (credit_return !== exp_credit) begin
            $display("Fail credit_return_o: got %h expected %h", credit_return, exp_credit);
            value_errs++;
        end
        // producer takes back whatever the buffer returns
        credits    += int'(credit_return);
        credit_sum += int'(credit_return);
        if (credits > ROB_DEPTH) begin
            $display("producer credits went above %0d", ROB_DEPTH);
            flow_errs++;
        end
        if (credits + live_q.size() != ROB_DEPTH) begin
            $display("credits %0d and %0d live entries do not add up", credits, live_q.size());
            flow_errs++;
        end
        if (live_q.size() == ROB_DEPTH && credits != 0) begin
            $display("buffer is full but the producer still holds %0d credits", credits);
            flow_errs++;
        end
    endtask

    // totals over the whole run
    task automatic check_totals();
        if (credit_sum != commit_cnt + kill_cnt) begin
            $display("credit returns total %0d, commits plus rolled back entries are %0d",
                     credit_sum, commit_cnt + kill_cnt);
            flow_errs++;
        end
        if (credits != ROB_DEPTH) begin
            $display("producer ended with %0d credits instead of all of them", credits);
            flow_errs++;
        end
    endtask

    // ==============================
    // main sequence
    // ==============================
    initial begin
        row_t drain_row;
        seed           = 50;
        next_age       = 0;
        exp_tail       = 0;
        credits        = ROB_DEPTH;
        credit_sum     = 0;
        commit_cnt     = 0;
        kill_cnt       = 0;
        value_errs     = 0;
        flow_errs      = 0;
        cycle_cnt      = 0;
        cycle_limit    = 0;
        reset          = 1'b1;
        disp_valid     = 1'b0;
        disp_req       = '0;
        wb_valid       = 1'b0;
        wb_req         = '0;
        mispredict     = 1'b0;
        mispredict_idx = '0;
        build_table();
        cycle_limit = rows.size() + TIMEOUT_SLACK;

        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        reset = 1'b0;
        check_reset_state();

        foreach (rows[i]) begin
            run_cycle(rows[i]);
        end
        // finish open entries one result per cycle until all retire
        while (live_q.size() > 0) begin
            drain_row.disp   = 1'b0;
            drain_row.wb_age = oldest_unwritten();
            drain_row.mp     = 1'b0;
            drain_row.mp_age = -1;
            run_cycle(drain_row);
        end
        check_totals();

        $display("errors: %0d value, %0d flow", value_errs, flow_errs);
        if (value_errs + flow_errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- compile.f
rob_pkg.sv
rob_alloc.sv
rob_entry_table.sv
rob_commit.sv
rob_top.sv
tb_clock_gen.sv
tb_rob.sv

//--- run.sh
#!/bin/sh
# build the reorder buffer testbench with verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module tb_rob -f compile.f -o sim_rob

./obj_dir/sim_rob > sim.log 2>&1
cat sim.log

if grep -q "^sim passed$" sim.log; then
    echo "run.sh: testbench reported success"
    exit 0
fi
echo "run.sh: testbench did not report success"
exit 1
